/* project.f */
hw/cipher_stream_pkg.sv
hw/cipher_regs_pkg.sv
hw/cipher_regs.sv
hw/xtea_pipe.sv
hw/stream_fifo.sv
hw/status_gen.sv
hw/cipher_stream_top.sv
bench/tb_cipher_stream.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the streaming XTEA engine testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
   --top-module tb_cipher_stream \
   -f project.f \
   -o sim_tb_cipher_stream

./obj_dir/sim_tb_cipher_stream > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
echo "Simulation finished without a reported failure"

/* bench/tb_cipher_stream.sv */
// Testbench for the streaming XTEA engine.
// Loads a key, sends random packets with and without output
// back-pressure, and compares every output beat and status word
// with values from a local XTEA model. Also reads back the key
// registers and the finished packet count.
`default_nettype none

module tb_cipher_stream
   import cipher_stream_pkg::*, cipher_regs_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int WAIT_LIMIT = 20000;

   logic                  m_axi_mm2s_aclk;
   logic                  rst_n_i;
   logic [DATA_W-1:0]     in_tdata_i;
   logic                  in_tlast_i;
   logic                  in_tvalid_i;
   logic                  in_tready_o;
   logic [DATA_W-1:0]     out_tdata_o;
   logic                  out_tlast_o;
   logic                  out_tvalid_o;
   logic                  out_tready_i;
   logic [31:0]           sts_tdata_o;
   logic                  sts_tlast_o;
   logic                  sts_tvalid_o;
   logic                  sts_tready_i;
   logic                  reg_wr_i;
   logic [REG_ADDR_W-1:0] reg_addr_i;
   logic [31:0]           reg_wdata_i;
   logic [31:0]           reg_rdata_o;

   beat_t       exp_q[$];          // Expected output beats, in order
   int          sts_len_q[$];      // Lengths of sent packets awaiting status
   key_t        cur_key;
   logic [31:0] in_rng;
   logic [31:0] out_rng;
   int          check_errors;
   int          timeouts;
   int          pkts_sent;
   int          sts_idx;
   bit          ready_mode;        // 1 selects long output stalls
   bit          saw_stall;

   cipher_stream_top u_cipher_stream_top (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .in_tdata_i      (in_tdata_i),
      .in_tlast_i      (in_tlast_i),
      .in_tvalid_i     (in_tvalid_i),
      .in_tready_o     (in_tready_o),
      .out_tdata_o     (out_tdata_o),
      .out_tlast_o     (out_tlast_o),
      .out_tvalid_o    (out_tvalid_o),
      .out_tready_i    (out_tready_i),
      .sts_tdata_o     (sts_tdata_o),
      .sts_tlast_o     (sts_tlast_o),
      .sts_tvalid_o    (sts_tvalid_o),
      .sts_tready_i    (sts_tready_i),
      .reg_wr_i        (reg_wr_i),
      .reg_addr_i      (reg_addr_i),
      .reg_wdata_i     (reg_wdata_i),
      .reg_rdata_o     (reg_rdata_o)
   );

   initial
   begin
      m_axi_mm2s_aclk = 1'b0;
      forever #5 m_axi_mm2s_aclk = ~m_axi_mm2s_aclk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Plain 32-cycle XTEA encryption with v0 in the upper word
   function automatic logic [63:0] xtea_encrypt(input logic [63:0] pt, input key_t k);
      logic [31:0] v0;
      logic [31:0] v1;
      logic [31:0] sum;
      v0  = pt[63:32];
      v1  = pt[31:0];
      sum = 32'd0;
      for (int r = 0; r < 32; r++)
      begin
         v0  = v0 + ((((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + k[sum & 32'd3]));
         sum = sum + 32'h9E37_79B9;
         v1  = v1 + ((((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + k[(sum >> 11) & 32'd3]));
      end
      return {v0, v1};
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         check_errors++;
      end
   endtask

   task automatic finish_run();
      $display("Check errors: %0d, timeouts: %0d", check_errors, timeouts);
      if (check_errors == 0 && timeouts == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout while waiting: %s", what);
      timeouts++;
      finish_run();
   endtask

   task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
      reg_wr_i    = 1'b1;
      reg_addr_i  = addr;
      reg_wdata_i = data;
      @(negedge m_axi_mm2s_aclk);
      reg_wr_i    = 1'b0;
   endtask

   // Starts and ends on a falling edge
   task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
      reg_addr_i = addr;
      #1 data = reg_rdata_o;       // Sampled once the combinational read settles
      @(negedge m_axi_mm2s_aclk);
   endtask

   task automatic load_key();
      logic [31:0] rd;
      for (int i = 0; i < 4; i++)
      begin
         in_rng     = xorshift32(in_rng);
         cur_key[i] = in_rng;
         reg_write(REG_ADDR_W'(i), cur_key[i]);
      end
      for (int i = 0; i < 4; i++)
      begin
         reg_read(REG_ADDR_W'(i), rd);
         check_value($sformatf("reg_rdata_o key%0d", i), rd, cur_key[i]);
      end
   endtask

   task automatic check_pkt_count();
      logic [31:0] rd;
      reg_read(REG_PKT_COUNT, rd);
      check_value("reg_rdata_o pkt_count", rd, pkts_sent);
   endtask

   // Starts and ends on a falling edge
   task automatic send_beat(input logic [63:0] d, input logic l, input int gap);
      int waited;
      repeat (gap) @(negedge m_axi_mm2s_aclk);
      in_tdata_i  = d;
      in_tlast_i  = l;
      in_tvalid_i = 1'b1;
      waited      = 0;
      while (!in_tready_o)
      begin
         saw_stall = 1'b1;
         if (waited > WAIT_LIMIT)
            report_timeout("in_tready_o never rose");
         @(negedge m_axi_mm2s_aclk);
         waited++;
      end
      exp_q.push_back('{data: xtea_encrypt(d, cur_key), last: l}); // Moves on next edge
      @(negedge m_axi_mm2s_aclk);
      in_tvalid_i = 1'b0;
   endtask

   task automatic send_packet(input int max_gap);
      int len;
      in_rng = xorshift32(in_rng);
      len    = 1 + int'(in_rng % 8);
      for (int b = 0; b < len; b++)
      begin
         in_rng = xorshift32(in_rng);
         send_beat({in_rng, xorshift32(in_rng ^ 32'h5A5A_0F0F)}, b == len - 1,
                   int'(in_rng[7:0]) % (max_gap + 1));
      end
      sts_len_q.push_back(len);
      pkts_sent++;
   endtask

   task automatic wait_idle();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 || sts_len_q.size() != 0 || sts_idx != 0)
      begin
         if (waited > WAIT_LIMIT)
            report_timeout("output and status streams to drain");
         @(negedge m_axi_mm2s_aclk);
         waited++;
      end
   endtask

   task automatic compare_beat();
      beat_t e;
      if (exp_q.size() == 0)
      begin
         $display("An output beat arrived although none was expected");
         check_errors++;
      end
      else
      begin
         e = exp_q.pop_front();
         check_value("out_tdata_o", out_tdata_o, e.data);
         check_value("out_tlast_o", out_tlast_o, e.last);
      end
   endtask

   task automatic compare_status();
      int len;
      if (sts_idx == 0)
      begin
         if (sts_len_q.size() == 0)
         begin
            $display("A status packet arrived for a packet that was never sent");
            check_errors++;
         end
         else
         begin
            len = sts_len_q.pop_front();
            // Tag 5 in the top nibble, reserved zero, beat count below
            check_value("sts_tdata_o header", sts_tdata_o, {4'd5, 12'd0, 16'(len)});
         end
      end
      else
         check_value("sts_tdata_o", sts_tdata_o, 0);
      check_value("sts_tlast_o", sts_tlast_o, sts_idx == STS_WORDS - 1);
      sts_idx = (sts_idx == STS_WORDS - 1) ? 0 : sts_idx + 1;
   endtask

   // Output side ready and checks in one process per falling edge
   initial
   begin
      int  stall_left;
      int  run_left;
      int  gap_left;
      bit  rdy;
      out_tready_i = 1'b0;
      sts_tready_i = 1'b0;
      out_rng      = 32'd42;
      stall_left   = 0;
      run_left     = 0;
      gap_left     = 0;
      forever
      begin
         @(negedge m_axi_mm2s_aclk);
         out_rng = xorshift32(out_rng);
         rdy     = 1'b1;
         if (ready_mode)
         begin
            if (stall_left != 0)
            begin
               rdy = 1'b0;
               stall_left--;
               if (stall_left == 0)
                  run_left = 1 + int'(out_rng[11:8] % 16);
            end
            else if (run_left != 0)
            begin
               rdy = out_rng[0];
               run_left--;
            end
            else
            begin
               rdy        = 1'b0;
               stall_left = 20 + int'(out_rng[21:16] % 40);
            end
         end
         if (gap_left != 0)
         begin
            rdy = 1'b0;                 // Lets the status packet finish
            gap_left--;
         end
         out_tready_i = rdy;
         sts_tready_i = 1'b1;
         if (out_tvalid_o && rdy)
         begin
            if (out_tlast_o)
               gap_left = 8;
            compare_beat();
         end
         if (sts_tvalid_o)
            compare_status();
      end
   end

   initial
   begin
      rst_n_i      = 1'b0;
      in_tdata_i   = '0;
      in_tlast_i   = 1'b0;
      in_tvalid_i  = 1'b0;
      reg_wr_i     = 1'b0;
      reg_addr_i   = '0;
      reg_wdata_i  = '0;
      cur_key      = '0;
      in_rng       = 32'd42;
      check_errors = 0;
      timeouts     = 0;
      pkts_sent    = 0;
      sts_idx      = 0;
      ready_mode   = 1'b0;
      saw_stall    = 1'b0;
      repeat (4) @(negedge m_axi_mm2s_aclk);
      rst_n_i = 1'b1;

      load_key();
      repeat (8) send_packet(2);        // Free-running output
      wait_idle();
      check_pkt_count();

      saw_stall  = 1'b0;
      ready_mode = 1'b1;
      repeat (16) send_packet(0);
      wait_idle();
      ready_mode = 1'b0;
      if (!saw_stall)
      begin
         $display("in_tready_o never fell under output back-pressure");
         check_errors++;
      end
      check_pkt_count();

      load_key();                       // New key while idle
      repeat (3) send_packet(1);
      wait_idle();
      check_pkt_count();
      finish_run();
   end

endmodule

`default_nettype wire

/* hw/cipher_stream_top.sv */
// Streaming XTEA engine between a DMA read and a DMA write channel.
// Input beats run through the cipher pipeline into the data FIFO,
// whose early-full flag throttles the input. A status packet per
// finished output packet leaves on the status stream. The register
// port loads the key and reads back the finished packet count.
`default_nettype none

module cipher_stream_top
   import cipher_stream_pkg::*, cipher_regs_pkg::*;
(
   input  wire logic                  m_axi_mm2s_aclk,
   input  wire logic                  rst_n_i,
   input  wire logic [DATA_W-1:0]     in_tdata_i,
   input  wire logic                  in_tlast_i,
   input  wire logic                  in_tvalid_i,
   output logic                       in_tready_o,
   output logic      [DATA_W-1:0]     out_tdata_o,
   output logic                       out_tlast_o,
   output logic                       out_tvalid_o,
   input  wire logic                  out_tready_i,
   output logic      [31:0]           sts_tdata_o,
   output logic                       sts_tlast_o,
   output logic                       sts_tvalid_o,
   input  wire logic                  sts_tready_i,
   input  wire logic                  reg_wr_i,
   input  wire logic [REG_ADDR_W-1:0] reg_addr_i,
   input  wire logic [31:0]           reg_wdata_i,
   output logic      [31:0]           reg_rdata_o
);

   key_t      key;
   beat_t     in_beat;
   beat_t     pipe_beat;
   beat_t     out_beat;
   sts_beat_t sts_wr_beat;
   sts_beat_t sts_rd_beat;
   logic      pipe_vld;
   logic      data_empty;
   logic      data_afull;
   logic      out_hs;
   logic      sts_wr;
   logic      sts_empty;
   logic      sts_afull;
   logic      pkt_done;

   assign in_beat = '{data: in_tdata_i, last: in_tlast_i};

   cipher_regs u_cipher_regs (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .reg_wr_i        (reg_wr_i),
      .reg_addr_i      (reg_addr_i),
      .reg_wdata_i     (reg_wdata_i),
      .reg_rdata_o     (reg_rdata_o),
      .pkt_done_i      (pkt_done),
      .key_o           (key)
   );

   xtea_pipe u_xtea_pipe (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .in_valid_i      (in_tvalid_i & in_tready_o),   // Input handshake
      .in_beat_i       (in_beat),
      .key_i           (key),
      .out_valid_o     (pipe_vld),
      .out_beat_o      (pipe_beat)
   );

   stream_fifo #(
      .WIDTH (DATA_W + 1),
      .DEPTH (DATA_FIFO_DEPTH),
      .AFULL (DATA_FIFO_AFULL)
   ) u_data_fifo (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .wr_en_i         (pipe_vld),
      .wr_data_i       (pipe_beat),
      .rd_en_i         (out_hs),
      .rd_data_o       (out_beat),
      .empty_o         (data_empty),
      .afull_o         (data_afull)
   );

   assign in_tready_o  = ~data_afull;
   assign out_tvalid_o = ~data_empty;
   assign out_tdata_o  = out_beat.data;
   assign out_tlast_o  = out_beat.last;
   assign out_hs       = out_tvalid_o & out_tready_i;

   status_gen u_status_gen (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .beat_done_i     (out_hs),
      .beat_last_i     (out_tlast_o),
      .sts_afull_i     (sts_afull),
      .sts_wr_o        (sts_wr),
      .sts_beat_o      (sts_wr_beat),
      .pkt_done_o      (pkt_done)
   );

   stream_fifo #(
      .WIDTH ($bits(sts_beat_t)),
      .DEPTH (STS_FIFO_DEPTH),
      .AFULL (STS_FIFO_AFULL)
   ) u_sts_fifo (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .wr_en_i         (sts_wr),
      .wr_data_i       (sts_wr_beat),
      .rd_en_i         (sts_tvalid_o & sts_tready_i),
      .rd_data_o       (sts_rd_beat),
      .empty_o         (sts_empty),
      .afull_o         (sts_afull)
   );

   assign sts_tvalid_o = ~sts_empty;
   assign sts_tdata_o  = sts_rd_beat.word.raw;
   assign sts_tlast_o  = sts_rd_beat.last;

endmodule

`default_nettype wire

/* hw/status_gen.sv */
// Status packet generator for the output stream.
// Counts beats leaving the engine and, when a packet's last beat
// moves, queues STS_WORDS status words for the status FIFO. Header
// carries STS_TAG and the beat count, the rest are zero and the final
// word has last set. pkt_done_o pulses as that final word is written.
`default_nettype none

module status_gen
   import cipher_stream_pkg::*;
(
   input  wire logic m_axi_mm2s_aclk,
   input  wire logic rst_n_i,
   input  wire logic beat_done_i,
   input  wire logic beat_last_i,
   input  wire logic sts_afull_i,
   output logic      sts_wr_o,
   output sts_beat_t sts_beat_o,
   output logic      pkt_done_o
);

   localparam int WCNT_W = $clog2(STS_WORDS + 1);

   logic [15:0]       beat_cnt;    // Beats of the packet in progress
   logic [15:0]       pkt_len;     // Length of the packet being reported
   logic [WCNT_W-1:0] words_left;
   sts_word_u         hdr;

   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (!rst_n_i)
         beat_cnt <= '0;
      else if (beat_done_i)
         beat_cnt <= beat_last_i ? '0 : beat_cnt + 16'd1;
   end

   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (beat_done_i && beat_last_i)
         pkt_len <= beat_cnt + 16'd1;
   end

   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (!rst_n_i)
         words_left <= '0;
      else if (beat_done_i && beat_last_i)
         words_left <= WCNT_W'(STS_WORDS);
      else if (sts_wr_o)
         words_left <= words_left - 1'b1;
   end

   always_comb
   begin
      hdr           = '0;
      hdr.fld.tag   = STS_TAG;
      hdr.fld.count = pkt_len;
   end

   assign sts_wr_o = (words_left != '0) && !sts_afull_i;

   always_comb
   begin
      sts_beat_o.word = '0;
      if (words_left == WCNT_W'(STS_WORDS))
         sts_beat_o.word = hdr;                      // First word out
      sts_beat_o.last = (words_left == WCNT_W'(1));
   end

   assign pkt_done_o = sts_wr_o && sts_beat_o.last;

   // A new packet may only end once the previous status is out or leaving now
   a_no_overlap: assert property (@(posedge m_axi_mm2s_aclk)
      disable iff (!rst_n_i)
      (beat_done_i && beat_last_i) |-> (words_left == '0) || pkt_done_o)
      else $error("status_gen packet ended with status words still pending");

endmodule

`default_nettype wire

/* hw/stream_fifo.sv */
// Synchronous register-array FIFO with an early-full flag.
// Read data shows the head entry combinationally, valid downstream
// is simply the inverted empty flag. afull_o is registered and sits
// high through reset, so upstream ready stays low until reset ends.
`default_nettype none

module stream_fifo #(
   parameter int WIDTH = 65,
   parameter int DEPTH = 64,
   parameter int AFULL = 30
) (
   input  wire logic             m_axi_mm2s_aclk,
   input  wire logic             rst_n_i,
   input  wire logic             wr_en_i,
   input  wire logic [WIDTH-1:0] wr_data_i,
   input  wire logic             rd_en_i,
   output logic      [WIDTH-1:0] rd_data_o,
   output logic                  empty_o,
   output logic                  afull_o
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_nxt;

   always_comb
   begin
      count_nxt = count;
      if (wr_en_i && !rd_en_i)
         count_nxt = count + 1'b1;
      else if (rd_en_i && !wr_en_i)
         count_nxt = count - 1'b1;
   end

   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (!rst_n_i)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         afull_o <= 1'b1;           // Holds off the source during reset
      end
      else
      begin
         if (wr_en_i)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd_en_i)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count   <= count_nxt;
         afull_o <= (count_nxt >= CNT_W'(AFULL));
      end
   end

   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (wr_en_i)
         mem[wr_ptr] <= wr_data_i;
   end

   assign rd_data_o = mem[rd_ptr];
   assign empty_o   = (count == '0);

   a_no_overflow: assert property (@(posedge m_axi_mm2s_aclk)
      disable iff (!rst_n_i) wr_en_i |-> (count != CNT_W'(DEPTH)))
      else $error("stream_fifo written while full");

   a_no_underflow: assert property (@(posedge m_axi_mm2s_aclk)
      disable iff (!rst_n_i) rd_en_i |-> !empty_o)
      else $error("stream_fifo read while empty");

endmodule

`default_nettype wire

/* hw/xtea_pipe.sv */
// Fully pipelined XTEA encryption, one full cycle (two half-rounds)
// per registered stage, PIPE_STAGES stages deep.
// Data word layout is v0 in bits 63:32 and v1 in bits 31:0.
// A beat entering with in_valid_i shows at the output PIPE_STAGES
// edges later. No stall, the consumer must always have room.
`default_nettype none

module xtea_pipe
   import cipher_stream_pkg::*, cipher_regs_pkg::*;
(
   input  wire logic m_axi_mm2s_aclk,
   input  wire logic rst_n_i,
   input  wire logic in_valid_i,
   input  beat_t     in_beat_i,
   input  key_t      key_i,
   output logic      out_valid_o,
   output beat_t     out_beat_o
);

   // One XTEA cycle with the sums of both half-rounds given
   function automatic logic [63:0] xtea_cycle(
      input logic [63:0] v,
      input key_t        k,
      input logic [31:0] sum_a,
      input logic [31:0] sum_b
   );
      logic [31:0] v0;
      logic [31:0] v1;
      v0 = v[63:32];
      v1 = v[31:0];
      v0 = v0 + ((((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum_a + k[sum_a[1:0]]));
      v1 = v1 + ((((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum_b + k[sum_b[12:11]]));
      return {v0, v1};
   endfunction

   beat_t stage_beat [PIPE_STAGES];
   logic  stage_vld  [PIPE_STAGES];

   for (genvar i = 0; i < PIPE_STAGES; i++)
   begin : g_stage
      // Round sums are fixed per stage
      localparam logic [31:0] SUM_A = XTEA_DELTA * 32'(i);
      localparam logic [31:0] SUM_B = XTEA_DELTA * 32'(i + 1);

      beat_t prev_beat;
      logic  prev_vld;

      if (i == 0)
      begin : g_first
         assign prev_beat = in_beat_i;
         assign prev_vld  = in_valid_i;
      end
      else
      begin : g_next
         assign prev_beat = stage_beat[i-1];
         assign prev_vld  = stage_vld[i-1];
      end

      always_ff @(posedge m_axi_mm2s_aclk)
      begin
         if (!rst_n_i)
            stage_vld[i] <= 1'b0;
         else
            stage_vld[i] <= prev_vld;
      end

      always_ff @(posedge m_axi_mm2s_aclk)
      begin
         stage_beat[i].data <= xtea_cycle(prev_beat.data, key_i, SUM_A, SUM_B);
         stage_beat[i].last <= prev_beat.last;   // Last rides with its data
      end
   end

   assign out_valid_o = stage_vld[PIPE_STAGES-1];
   assign out_beat_o  = stage_beat[PIPE_STAGES-1];

   // Every stage valid is cleared, so the output must be clean after reset
   a_out_valid_known: assert property (@(posedge m_axi_mm2s_aclk)
      disable iff (!rst_n_i) !$isunknown(out_valid_o))
      else $error("xtea_pipe output valid unknown after reset");

endmodule

`default_nettype wire

/* hw/cipher_regs.sv */
// Key and packet counter registers behind a simple strobe port.
// A write lands on the edge where reg_wr_i is high. Reads are
// combinational on reg_addr_i, unmapped addresses read as zero.
// The key should only change while no beats are in flight.
`default_nettype none

module cipher_regs
   import cipher_regs_pkg::*;
(
   input  wire logic                  m_axi_mm2s_aclk,
   input  wire logic                  rst_n_i,
   input  wire logic                  reg_wr_i,
   input  wire logic [REG_ADDR_W-1:0] reg_addr_i,
   input  wire logic [31:0]           reg_wdata_i,
   output logic      [31:0]           reg_rdata_o,
   input  wire logic                  pkt_done_i,
   output key_t                       key_o
);

   key_t        key_q;
   logic [31:0] pkt_count;

   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (!rst_n_i)
      begin
         key_q <= '0;
      end
      else if (reg_wr_i)
      begin
         case (reg_addr_i)
            REG_KEY0: key_q[0] <= reg_wdata_i;
            REG_KEY1: key_q[1] <= reg_wdata_i;
            REG_KEY2: key_q[2] <= reg_wdata_i;
            REG_KEY3: key_q[3] <= reg_wdata_i;
            default: ;                 // Count is not writable
         endcase
      end
   end

   // Finished packets, one pulse per status packet
   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (!rst_n_i)
         pkt_count <= '0;
      else if (pkt_done_i)
         pkt_count <= pkt_count + 32'd1;
   end

   always_comb
   begin
      case (reg_addr_i)
         REG_KEY0:      reg_rdata_o = key_q[0];
         REG_KEY1:      reg_rdata_o = key_q[1];
         REG_KEY2:      reg_rdata_o = key_q[2];
         REG_KEY3:      reg_rdata_o = key_q[3];
         REG_PKT_COUNT: reg_rdata_o = pkt_count;
         default:       reg_rdata_o = '0;
      endcase
   end

   assign key_o = key_q;

endmodule

`default_nettype wire

/* hw/cipher_regs_pkg.sv */
// Register map of the engine's strobe-style register port.
// Holds the addresses and the key type handed to the cipher pipeline.
// Key word 0 is k[0] of the XTEA schedule.
`default_nettype none

package cipher_regs_pkg;

   localparam int REG_ADDR_W = 3;

   // Key words, index 0 to 3 as in the XTEA key schedule
   typedef logic [3:0][31:0] key_t;

   localparam logic [REG_ADDR_W-1:0] REG_KEY0      = 3'd0;
   localparam logic [REG_ADDR_W-1:0] REG_KEY1      = 3'd1;
   localparam logic [REG_ADDR_W-1:0] REG_KEY2      = 3'd2;
   localparam logic [REG_ADDR_W-1:0] REG_KEY3      = 3'd3;
   localparam logic [REG_ADDR_W-1:0] REG_PKT_COUNT = 3'd4; // Read only

endpackage

`default_nettype wire

/* hw/cipher_stream_pkg.sv */
// Types and constants shared by the streaming XTEA engine.
// Covers the stream beats, the status word layout and the pipeline
// and FIFO sizing. Import it by wildcard in the module header.
`default_nettype none

package cipher_stream_pkg;

   localparam int DATA_W = 64;

   // One beat on the data streams
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
   } beat_t;

   // Header layout of the first status word
   typedef struct packed {
      logic [3:0]  tag;
      logic [11:0] rsvd;
      logic [15:0] count;       // Beats in the finished packet
   } sts_hdr_t;

   typedef union packed {
      logic [31:0] raw;
      sts_hdr_t    fld;
   } sts_word_u;

   typedef struct packed {
      sts_word_u word;
      logic      last;
   } sts_beat_t;

   localparam logic [3:0]  STS_TAG     = 4'd5;
   localparam int          STS_WORDS   = 6;
   localparam logic [31:0] XTEA_DELTA  = 32'h9E37_79B9;
   localparam int          PIPE_STAGES = 32;

   localparam int DATA_FIFO_DEPTH = 64;
   localparam int DATA_FIFO_AFULL = DATA_FIFO_DEPTH - PIPE_STAGES - 2; // Room for beats in flight
   localparam int STS_FIFO_DEPTH  = 16;
   localparam int STS_FIFO_AFULL  = STS_FIFO_DEPTH - STS_WORDS;

endpackage

`default_nettype wire
